// ==== sources.f ====
+incdir+bench
verilog/usbf_pkg.sv
verilog/usbf_csr_decode.sv
verilog/usbf_csr_regs.sv
verilog/usbf_ep_cmd.sv
verilog/usbf_intr.sv
verilog/usbf_csr_top.sv
bench/tb_usbf_csr.sv

// ==== Bender.yml ====
package:
  name: usbf_csr

sources:
  - files:
      - verilog/usbf_pkg.sv
      - verilog/usbf_csr_decode.sv
      - verilog/usbf_csr_regs.sv
      - verilog/usbf_ep_cmd.sv
      - verilog/usbf_intr.sv
      - verilog/usbf_csr_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_usbf_csr.sv

// ==== bench/tb_usbf_csr_ref.svh ====
`ifndef TB_USBF_CSR_REF_SVH
`define TB_USBF_CSR_REF_SVH

// Writable field masks of the register map
localparam logic [31:0] FUNC_CTRL_MASK = 32'h0000_03FF;
localparam logic [31:0] FUNC_ADDR_MASK = 32'h0000_007F;
localparam logic [31:0] EP_CFG_MASK    = 32'h0000_000F;
localparam logic [31:0] TX_LEN_MASK    = 32'h0000_07FF;

// Expected read word from the shadow registers and the status inputs
function automatic logic [DATA_W-1:0] expected_read(input logic rd,
                                                    input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] w;
    logic [1:0]        k;
    ep_status_t        st;
    int                i;
    w  = '0;
    k  = 2'((addr - 8'h20) >> 4);
    st = ep_status[k];
    if (rd && addr < 8'h20) begin
        case (addr)
            8'h00: w = {22'h0, m_fctrl};
            8'h04: w = {17'h0, frame, linestate, m_rst_flag, m_sof_flag};
            8'h08: w = {25'h0, m_faddr};
            8'h0C: begin
                for (i = 0; i < EP_NUM; i++) begin
                    w[i]      = m_rx_flag[i];
                    w[16 + i] = m_tx_flag[i];
                end
            end
            default: w = '0;
        endcase
    end else if (rd && addr < 8'h60) begin
        // RX_CTRL and the window holes read as zero
        case (addr[3:0])
            4'h0: w = {28'h0, m_cfg[k][3], m_stall[k], m_cfg[k][1:0]};
            4'h4: w = {21'h0, m_txlen[k]};
            4'hC: w = {11'h0, st.tx_err, st.tx_busy, st.rx_err, st.rx_setup, st.rx_ready,
                       5'h0, st.rx_count};
            default: w = '0;
        endcase
    end
    return w;
endfunction

// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

`endif

// ==== bench/tb_usbf_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_usbf_csr;
    import usbf_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic                         clk;
    logic                         rst_n;
    csr_req_t                     req;
    ep_status_t [EP_NUM-1:0]      ep_status;
    logic [1:0]                   linestate;
    logic [FRAME_W-1:0]           frame;
    intr_event_t                  events;
    logic [DATA_W-1:0]            rdata;
    phy_ctrl_t                    phy_ctrl;
    logic [DEV_ADDR_W-1:0]        dev_addr;
    logic [EP_NUM-1:0]            iso;
    logic [EP_NUM-1:0][LEN_W-1:0] tx_len;
    ep_cmd_t [EP_NUM-1:0]         cmd;
    logic [EP_NUM-1:0]            stall;
    logic                         intr;

    // Shadow of the register file
    logic [9:0]                   m_fctrl;
    logic [6:0]                   m_faddr;
    logic [EP_NUM-1:0][3:0]       m_cfg;
    logic [EP_NUM-1:0][LEN_W-1:0] m_txlen;
    logic [EP_NUM-1:0]            m_stall;
    ep_cmd_t [EP_NUM-1:0]         m_cmd;
    logic                         m_sof_flag;
    logic                         m_rst_flag;
    logic [EP_NUM-1:0]            m_rx_flag;
    logic [EP_NUM-1:0]            m_tx_flag;

    logic [15:0] lfsr_state;
    int          errors = 0;
    int          cycles = 0;

    `include "tb_usbf_csr_ref.svh"

    usbf_csr_top DUT (
        .hclk_i      (clk),
        .rst_n_i     (rst_n),
        .req_i       (req),
        .ep_status_i (ep_status),
        .linestate_i (linestate),
        .frame_i     (frame),
        .event_i     (events),
        .rdata_o     (rdata),
        .phy_ctrl_o  (phy_ctrl),
        .dev_addr_o  (dev_addr),
        .iso_o       (iso),
        .tx_len_o    (tx_len),
        .cmd_o       (cmd),
        .stall_o     (stall),
        .intr_o      (intr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic reset_model();
        m_fctrl    = '0;
        m_faddr    = '0;
        m_cfg      = '0;
        m_txlen    = '0;
        m_stall    = '0;
        m_cmd      = '0;
        m_sof_flag = 1'b0;
        m_rst_flag = 1'b0;
        m_rx_flag  = '0;
        m_tx_flag  = '0;
    endtask

    task automatic check_outputs();
        logic [DATA_W-1:0] exp_rd;
        phy_ctrl_t         exp_phy;
        logic [EP_NUM-1:0] exp_iso;
        logic              exp_intr;
        int                i;
        exp_rd = expected_read(req.rd_en, req.addr);
        exp_phy.hs_chirp_en = m_fctrl[0];
        exp_phy.dmpulldown  = m_fctrl[1];
        exp_phy.dppulldown  = m_fctrl[2];
        exp_phy.termselect  = m_fctrl[3];
        exp_phy.xcvrselect  = m_fctrl[5:4];
        exp_phy.opmode      = m_fctrl[7:6];
        exp_intr = (m_sof_flag & m_fctrl[8]) | (m_rst_flag & m_fctrl[9]);
        for (i = 0; i < EP_NUM; i++) begin
            exp_iso[i] = m_cfg[i][3];
            exp_intr   = exp_intr | (m_rx_flag[i] & m_cfg[i][0]) | (m_tx_flag[i] & m_cfg[i][1]);
        end
        if (rdata !== exp_rd)
            report_mismatch($sformatf("rdata_o at 0x%h", req.addr), rdata, exp_rd);
        if (phy_ctrl !== exp_phy) report_mismatch("phy_ctrl_o", phy_ctrl, exp_phy);
        if (dev_addr !== m_faddr) report_mismatch("dev_addr_o", dev_addr, m_faddr);
        if (iso !== exp_iso) report_mismatch("iso_o", iso, exp_iso);
        if (tx_len !== m_txlen) report_mismatch("tx_len_o", tx_len, m_txlen);
        if (cmd !== m_cmd) report_mismatch("cmd_o", cmd, m_cmd);
        if (stall !== m_stall) report_mismatch("stall_o", stall, m_stall);
        if (intr !== exp_intr) report_mismatch("intr_o", intr, exp_intr);
    endtask

    // Apply the access and events of the cycle that ends at this edge
    task automatic advance_model();
        logic              is_ep;
        logic [1:0]        ep;
        logic [DATA_W-1:0] d;
        logic              clr_sof;
        logic              clr_rst;
        logic [EP_NUM-1:0] clr_rx;
        logic [EP_NUM-1:0] clr_tx;
        int                i;
        d       = req.wdata;
        is_ep   = req.addr >= 8'h20 && req.addr < 8'h60;
        ep      = 2'((req.addr - 8'h20) >> 4);
        clr_sof = 1'b0;
        clr_rst = 1'b0;
        clr_rx  = '0;
        clr_tx  = '0;
        m_cmd   = '0;
        for (i = 0; i < EP_NUM; i++) begin
            if (req.wt_en && is_ep && req.addr[3:0] == 4'h0 && ep == i && d[2])
                m_stall[i] = 1'b1;
            else if (ep_status[i].rx_setup)
                m_stall[i] = 1'b0;
        end
        if (req.wt_en && !is_ep) begin
            case (req.addr)
                8'h00: m_fctrl = 10'(d & FUNC_CTRL_MASK);
                8'h04: {clr_rst, clr_sof} = d[1:0];
                8'h08: m_faddr = 7'(d & FUNC_ADDR_MASK);
                8'h0C: {clr_tx, clr_rx} = {d[19:16], d[3:0]};
                default: ;
            endcase
        end else if (req.wt_en) begin
            case (req.addr[3:0])
                4'h0: m_cfg[ep] = 4'(d & EP_CFG_MASK);
                4'h4: begin
                    m_txlen[ep]         = 11'(d & TX_LEN_MASK);
                    m_cmd[ep].tx_start  = d[17];
                    m_cmd[ep].tx_flush  = d[16];
                end
                4'h8: begin
                    m_cmd[ep].rx_flush  = d[0];
                    m_cmd[ep].rx_accept = d[1];
                end
                default: ;
            endcase
        end
        m_sof_flag = events.sof | (m_sof_flag & ~clr_sof);
        m_rst_flag = events.bus_rst | (m_rst_flag & ~clr_rst);
        m_rx_flag  = events.rx_ready | (m_rx_flag & ~clr_rx);
        m_tx_flag  = events.tx_complete | (m_tx_flag & ~clr_tx);
    endtask

    // ----------------------------------------------------------
    // Comparing process sees the values of the ending cycle
    // ----------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            reset_model();
        end else begin
            check_outputs();
            advance_model();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: stimulus still running after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [ADDR_W-1:0] ep_addr(input int k, input logic [ADDR_W-1:0] ofs);
        return EP_BASE + ADDR_W'(k) * EP_STRIDE + ofs;
    endfunction

    // Each access holds one cycle and is followed by one idle cycle
    task automatic write_reg(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        @(negedge clk);
        req = {1'b1, 1'b0, a, d};
        @(negedge clk);
        req = '0;
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] a);
        @(negedge clk);
        req = {1'b0, 1'b1, a, 32'h0};
        @(negedge clk);
        req = '0;
    endtask

    // New random status in the same cycle as the read
    task automatic read_with_status(input logic [ADDR_W-1:0] a);
        int i;
        @(negedge clk);
        for (i = 0; i < EP_NUM; i++) begin
            ep_status[i] = 16'(rand_bits(16));
        end
        linestate = 2'(rand_bits(2));
        frame     = 11'(rand_bits(FRAME_W));
        req       = {1'b0, 1'b1, a, 32'h0};
        @(negedge clk);
        req = '0;
    endtask

    task automatic pulse_events(input logic [9:0] ev);
        @(negedge clk);
        events = ev;
        @(negedge clk);
        events = '0;
    endtask

    task automatic pulse_setup(input int k);
        @(negedge clk);
        ep_status[k].rx_setup = 1'b1;
        @(negedge clk);
        ep_status[k].rx_setup = 1'b0;
    endtask

    initial begin
        int                k;
        int                n;
        logic [ADDR_W-1:0] a;
        rst_n      = 1'b0;
        req        = '0;
        ep_status  = '0;
        linestate  = '0;
        frame      = '0;
        events     = '0;
        lfsr_state = 16'd71;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset values, mapped registers and a few holes
        for (k = 0; k < 4; k++) read_reg(8'(4 * k));
        for (k = 0; k < EP_NUM; k++) begin
            for (n = 0; n < 4; n++) read_reg(ep_addr(k, 8'(4 * n)));
        end
        read_reg(8'h10);
        read_reg(8'h22);
        read_reg(8'h60);
        read_reg(8'hFC);

        // Random configuration writes with read-back
        repeat (64) begin
            k = int'(rand_bits(2));
            case (rand_bits(2))
                0: a = FUNC_CTRL_ADDR;
                1: a = FUNC_ADDR_ADDR;
                2: a = ep_addr(k, EP_CFG_OFS);
                default: a = ep_addr(k, EP_TX_CTRL_OFS);
            endcase
            write_reg(a, rand_bits(32));
            read_reg(a);
        end

        // Command pulses on each endpoint
        for (k = 0; k < EP_NUM; k++) begin
            write_reg(ep_addr(k, EP_TX_CTRL_OFS), 32'h0003_0000 | rand_bits(LEN_W));
            write_reg(ep_addr(k, EP_TX_CTRL_OFS), 32'h0002_0000);
            write_reg(ep_addr(k, EP_RX_CTRL_OFS), 32'h3);
            write_reg(ep_addr(k, EP_RX_CTRL_OFS), 32'h2);
        end

        // Stall cleared first, then set by CFG and cleared by setup
        for (k = 0; k < EP_NUM; k++) begin
            pulse_setup(k);
            write_reg(ep_addr(k, EP_CFG_OFS), 32'h4);
            repeat (3) @(negedge clk);
            pulse_setup(k);
            repeat (2) @(negedge clk);
        end

        // Event flags, masking and write-one-to-clear
        repeat (32) begin
            write_reg(FUNC_CTRL_ADDR, rand_bits(2) << FC_SOF_EN_B);
            k = int'(rand_bits(2));
            write_reg(ep_addr(k, EP_CFG_OFS), rand_bits(2));
            pulse_events(10'(rand_bits(10)));
            read_reg(FUNC_STAT_ADDR);
            read_reg(EP_INTSTS_ADDR);
            write_reg(FUNC_STAT_ADDR, rand_bits(2));
            write_reg(EP_INTSTS_ADDR, (rand_bits(EP_NUM) << INTSTS_TX_B) | rand_bits(EP_NUM));
            read_reg(FUNC_STAT_ADDR);
            read_reg(EP_INTSTS_ADDR);
        end

        // Status inputs seen in the read cycle
        repeat (64) begin
            k = int'(rand_bits(2));
            read_with_status(ep_addr(k, EP_STS_OFS));
            read_with_status(FUNC_STAT_ADDR);
        end

        repeat (4) @(negedge clk);
        $display("Cycles run: %0d, errors: %0d", cycles, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/usbf_csr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module usbf_csr_top (
    input  wire                                                  hclk_i,
    input  wire                                                  rst_n_i,
    input  usbf_pkg::csr_req_t                                   req_i,
    input  usbf_pkg::ep_status_t [usbf_pkg::EP_NUM-1:0]          ep_status_i,
    input  wire  [1:0]                                           linestate_i,
    input  wire  [usbf_pkg::FRAME_W-1:0]                         frame_i,
    input  usbf_pkg::intr_event_t                                event_i,
    output logic [usbf_pkg::DATA_W-1:0]                          rdata_o,
    output usbf_pkg::phy_ctrl_t                                  phy_ctrl_o,
    output logic [usbf_pkg::DEV_ADDR_W-1:0]                      dev_addr_o,
    output logic [usbf_pkg::EP_NUM-1:0]                          iso_o,
    output logic [usbf_pkg::EP_NUM-1:0][usbf_pkg::LEN_W-1:0]     tx_len_o,
    output usbf_pkg::ep_cmd_t [usbf_pkg::EP_NUM-1:0]             cmd_o,
    output logic [usbf_pkg::EP_NUM-1:0]                          stall_o,
    output logic                                                 intr_o
);
    import usbf_pkg::*;

    csr_sel_t          sel;
    logic [1:0]        func_flags;
    logic [EP_NUM-1:0] rx_flags;
    logic [EP_NUM-1:0] tx_flags;
    logic [EP_NUM-1:0] int_rx_en;
    logic [EP_NUM-1:0] int_tx_en;
    logic              sof_int_en;
    logic              rst_int_en;
    logic [EP_NUM-1:0] rx_setup;

    for (genvar i = 0; i < EP_NUM; i++) begin : g_setup
        assign rx_setup[i] = ep_status_i[i].rx_setup;
    end

    usbf_csr_decode u_decode (
        .hclk_i  (hclk_i),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .sel_o   (sel)
    );

    usbf_csr_regs u_regs (
        .hclk_i       (hclk_i),
        .rst_n_i      (rst_n_i),
        .sel_i        (sel),
        .ep_status_i  (ep_status_i),
        .linestate_i  (linestate_i),
        .frame_i      (frame_i),
        .stall_i      (stall_o),
        .func_flags_i (func_flags),
        .rx_flags_i   (rx_flags),
        .tx_flags_i   (tx_flags),
        .phy_ctrl_o   (phy_ctrl_o),
        .dev_addr_o   (dev_addr_o),
        .iso_o        (iso_o),
        .int_rx_en_o  (int_rx_en),
        .int_tx_en_o  (int_tx_en),
        .sof_int_en_o (sof_int_en),
        .rst_int_en_o (rst_int_en),
        .tx_len_o     (tx_len_o),
        .rdata_o      (rdata_o)
    );

    usbf_ep_cmd u_ep_cmd (
        .hclk_i     (hclk_i),
        .rst_n_i    (rst_n_i),
        .sel_i      (sel),
        .rx_setup_i (rx_setup),
        .cmd_o      (cmd_o),
        .stall_o    (stall_o)
    );

    usbf_intr u_intr (
        .hclk_i       (hclk_i),
        .rst_n_i      (rst_n_i),
        .sel_i        (sel),
        .event_i      (event_i),
        .sof_int_en_i (sof_int_en),
        .rst_int_en_i (rst_int_en),
        .int_rx_en_i  (int_rx_en),
        .int_tx_en_i  (int_tx_en),
        .func_flags_o (func_flags),
        .rx_flags_o   (rx_flags),
        .tx_flags_o   (tx_flags),
        .intr_o       (intr_o)
    );

endmodule

`default_nettype wire

// ==== verilog/usbf_intr.sv ====
`timescale 1ns/1ps
`default_nettype none

module usbf_intr (
    input  wire                          hclk_i,
    input  wire                          rst_n_i,
    input  usbf_pkg::csr_sel_t           sel_i,
    input  usbf_pkg::intr_event_t        event_i,
    input  wire                          sof_int_en_i,
    input  wire                          rst_int_en_i,
    input  wire  [usbf_pkg::EP_NUM-1:0]  int_rx_en_i,
    input  wire  [usbf_pkg::EP_NUM-1:0]  int_tx_en_i,
    output logic [1:0]                   func_flags_o,
    output logic [usbf_pkg::EP_NUM-1:0]  rx_flags_o,
    output logic [usbf_pkg::EP_NUM-1:0]  tx_flags_o,
    output logic                         intr_o
);
    import usbf_pkg::*;

    localparam int FLAG_W = 2 + 2 * EP_NUM;

    logic              stat_wr;
    logic              intsts_wr;
    logic [FLAG_W-1:0] flag_set;
    logic [FLAG_W-1:0] flag_clr;
    logic [FLAG_W-1:0] flags_q;

    assign stat_wr   = sel_i.wr && (sel_i.kind == REG_FUNC_STAT);
    assign intsts_wr = sel_i.wr && (sel_i.kind == REG_EP_INTSTS);

    // Flag vector layout {tx, rx, rst, sof}
    assign flag_set = {event_i.tx_complete, event_i.rx_ready, event_i.bus_rst, event_i.sof};
    assign flag_clr = {{EP_NUM{intsts_wr}} & sel_i.wdata[INTSTS_TX_B +: EP_NUM],
                       {EP_NUM{intsts_wr}} & sel_i.wdata[INTSTS_RX_B +: EP_NUM],
                       stat_wr & sel_i.wdata[FS_RST_B],
                       stat_wr & sel_i.wdata[FS_SOF_B]};

    // ----------------------------------------------------------
    // Event flags where set wins over write-one-to-clear
    // ----------------------------------------------------------
    always_ff @(posedge hclk_i) begin
        if (!rst_n_i) begin
            flags_q <= '0;
        end else begin
            flags_q <= flag_set | (flags_q & ~flag_clr);
        end
    end

    assign func_flags_o = flags_q[1:0];
    assign rx_flags_o   = flags_q[2 +: EP_NUM];
    assign tx_flags_o   = flags_q[2 + EP_NUM +: EP_NUM];

    // Masked interrupt line
    assign intr_o = (func_flags_o[0] & sof_int_en_i) |
                    (func_flags_o[1] & rst_int_en_i) |
                    (|(rx_flags_o & int_rx_en_i))   |
                    (|(tx_flags_o & int_tx_en_i));

    // A flag only falls after a write-one-to-clear access
    a_flag_fall_on_clr: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
        $past(rst_n_i) && (($past(flags_q) & ~flags_q) != '0) |->
        $past(stat_wr || intsts_wr));

endmodule

`default_nettype wire

// ==== verilog/usbf_ep_cmd.sv ====
`timescale 1ns/1ps
`default_nettype none

module usbf_ep_cmd (
    input  wire                                         hclk_i,
    input  wire                                         rst_n_i,
    input  usbf_pkg::csr_sel_t                          sel_i,
    input  wire  [usbf_pkg::EP_NUM-1:0]                 rx_setup_i,
    output usbf_pkg::ep_cmd_t [usbf_pkg::EP_NUM-1:0]    cmd_o,
    output logic [usbf_pkg::EP_NUM-1:0]                 stall_o
);
    import usbf_pkg::*;

    logic [EP_NUM-1:0] tx_wr;
    logic [EP_NUM-1:0] rx_wr;
    logic [EP_NUM-1:0] cfg_wr;

    // One-hot write strobes for the addressed endpoint
    always_comb begin
        tx_wr  = '0;
        rx_wr  = '0;
        cfg_wr = '0;
        if (sel_i.wr) begin
            case (sel_i.kind)
                REG_EP_TX_CTRL: tx_wr[sel_i.ep]  = 1'b1;
                REG_EP_RX_CTRL: rx_wr[sel_i.ep]  = 1'b1;
                REG_EP_CFG:     cfg_wr[sel_i.ep] = 1'b1;
                default: ;
            endcase
        end
    end

    for (genvar i = 0; i < EP_NUM; i++) begin : g_ep
        always_ff @(posedge hclk_i) begin
            if (!rst_n_i) begin
                cmd_o[i]   <= '0;
                stall_o[i] <= 1'b0;
            end else begin
                // Pulse only in the cycle after the write
                cmd_o[i].tx_start  <= tx_wr[i] & sel_i.wdata[TX_START_B];
                cmd_o[i].tx_flush  <= tx_wr[i] & sel_i.wdata[TX_FLUSH_B];
                cmd_o[i].rx_flush  <= rx_wr[i] & sel_i.wdata[RX_FLUSH_B];
                cmd_o[i].rx_accept <= rx_wr[i] & sel_i.wdata[RX_ACCEPT_B];
                // Set has priority over the setup clear
                if (cfg_wr[i] && sel_i.wdata[CFG_STALL_B]) begin
                    stall_o[i] <= 1'b1;
                end else if (rx_setup_i[i]) begin
                    stall_o[i] <= 1'b0;
                end
            end
        end
    end

    // Every command pulse is one cycle wide
    a_pulse_once: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
        (cmd_o & $past(cmd_o)) == '0);

endmodule

`default_nettype wire

// ==== verilog/usbf_csr_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module usbf_csr_regs (
    input  wire                                                  hclk_i,
    input  wire                                                  rst_n_i,
    input  usbf_pkg::csr_sel_t                                   sel_i,
    input  usbf_pkg::ep_status_t [usbf_pkg::EP_NUM-1:0]          ep_status_i,
    input  wire  [1:0]                                           linestate_i,
    input  wire  [usbf_pkg::FRAME_W-1:0]                         frame_i,
    input  wire  [usbf_pkg::EP_NUM-1:0]                          stall_i,
    input  wire  [1:0]                                           func_flags_i,
    input  wire  [usbf_pkg::EP_NUM-1:0]                          rx_flags_i,
    input  wire  [usbf_pkg::EP_NUM-1:0]                          tx_flags_i,
    output usbf_pkg::phy_ctrl_t                                  phy_ctrl_o,
    output logic [usbf_pkg::DEV_ADDR_W-1:0]                      dev_addr_o,
    output logic [usbf_pkg::EP_NUM-1:0]                          iso_o,
    output logic [usbf_pkg::EP_NUM-1:0]                          int_rx_en_o,
    output logic [usbf_pkg::EP_NUM-1:0]                          int_tx_en_o,
    output logic                                                 sof_int_en_o,
    output logic                                                 rst_int_en_o,
    output logic [usbf_pkg::EP_NUM-1:0][usbf_pkg::LEN_W-1:0]     tx_len_o,
    output logic [usbf_pkg::DATA_W-1:0]                          rdata_o
);
    import usbf_pkg::*;

    // ----------------------------------------------------------
    // Configuration storage
    // ----------------------------------------------------------
    always_ff @(posedge hclk_i) begin
        if (!rst_n_i) begin
            phy_ctrl_o   <= '0;
            dev_addr_o   <= '0;
            iso_o        <= '0;
            int_rx_en_o  <= '0;
            int_tx_en_o  <= '0;
            sof_int_en_o <= 1'b0;
            rst_int_en_o <= 1'b0;
            tx_len_o     <= '0;
        end else if (sel_i.wr) begin
            case (sel_i.kind)
                REG_FUNC_CTRL: begin
                    phy_ctrl_o.hs_chirp_en <= sel_i.wdata[FC_CHIRP_B];
                    phy_ctrl_o.dmpulldown  <= sel_i.wdata[FC_DM_B];
                    phy_ctrl_o.dppulldown  <= sel_i.wdata[FC_DP_B];
                    phy_ctrl_o.termselect  <= sel_i.wdata[FC_TERM_B];
                    phy_ctrl_o.xcvrselect  <= sel_i.wdata[FC_XCVR_B +: 2];
                    phy_ctrl_o.opmode      <= sel_i.wdata[FC_OPMODE_B +: 2];
                    sof_int_en_o           <= sel_i.wdata[FC_SOF_EN_B];
                    rst_int_en_o           <= sel_i.wdata[FC_RST_EN_B];
                end
                REG_FUNC_ADDR: dev_addr_o <= sel_i.wdata[FA_DEV_B +: DEV_ADDR_W];
                REG_EP_CFG: begin
                    int_rx_en_o[sel_i.ep] <= sel_i.wdata[CFG_INT_RX_B];
                    int_tx_en_o[sel_i.ep] <= sel_i.wdata[CFG_INT_TX_B];
                    iso_o[sel_i.ep]       <= sel_i.wdata[CFG_ISO_B];
                end
                REG_EP_TX_CTRL: tx_len_o[sel_i.ep] <= sel_i.wdata[TX_LEN_B +: LEN_W];
                default: ;
            endcase
        end
    end

    // ----------------------------------------------------------
    // Read-back mux
    // ----------------------------------------------------------
    always_comb begin
        rdata_o = '0;
        if (sel_i.rd) begin
            case (sel_i.kind)
                REG_FUNC_CTRL: begin
                    rdata_o[FC_CHIRP_B]       = phy_ctrl_o.hs_chirp_en;
                    rdata_o[FC_DM_B]          = phy_ctrl_o.dmpulldown;
                    rdata_o[FC_DP_B]          = phy_ctrl_o.dppulldown;
                    rdata_o[FC_TERM_B]        = phy_ctrl_o.termselect;
                    rdata_o[FC_XCVR_B +: 2]   = phy_ctrl_o.xcvrselect;
                    rdata_o[FC_OPMODE_B +: 2] = phy_ctrl_o.opmode;
                    rdata_o[FC_SOF_EN_B]      = sof_int_en_o;
                    rdata_o[FC_RST_EN_B]      = rst_int_en_o;
                end
                REG_FUNC_STAT: begin
                    rdata_o[FS_SOF_B]              = func_flags_i[0];
                    rdata_o[FS_RST_B]              = func_flags_i[1];
                    rdata_o[FS_LINE_B +: 2]        = linestate_i;
                    rdata_o[FS_FRAME_B +: FRAME_W] = frame_i;
                end
                REG_FUNC_ADDR: rdata_o[FA_DEV_B +: DEV_ADDR_W] = dev_addr_o;
                REG_EP_INTSTS: begin
                    rdata_o[INTSTS_RX_B +: EP_NUM] = rx_flags_i;
                    rdata_o[INTSTS_TX_B +: EP_NUM] = tx_flags_i;
                end
                REG_EP_CFG: begin
                    rdata_o[CFG_INT_RX_B] = int_rx_en_o[sel_i.ep];
                    rdata_o[CFG_INT_TX_B] = int_tx_en_o[sel_i.ep];
                    rdata_o[CFG_STALL_B]  = stall_i[sel_i.ep];
                    rdata_o[CFG_ISO_B]    = iso_o[sel_i.ep];
                end
                // Command bits of TX_CTRL and RX_CTRL read as zero
                REG_EP_TX_CTRL: rdata_o[TX_LEN_B +: LEN_W] = tx_len_o[sel_i.ep];
                REG_EP_STS: begin
                    rdata_o[STS_COUNT_B +: LEN_W] = ep_status_i[sel_i.ep].rx_count;
                    rdata_o[STS_RX_READY_B]       = ep_status_i[sel_i.ep].rx_ready;
                    rdata_o[STS_RX_SETUP_B]       = ep_status_i[sel_i.ep].rx_setup;
                    rdata_o[STS_RX_ERR_B]         = ep_status_i[sel_i.ep].rx_err;
                    rdata_o[STS_TX_BUSY_B]        = ep_status_i[sel_i.ep].tx_busy;
                    rdata_o[STS_TX_ERR_B]         = ep_status_i[sel_i.ep].tx_err;
                end
                default: rdata_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/usbf_csr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module usbf_csr_decode (
    input  wire                 hclk_i,
    input  wire                 rst_n_i,
    input  usbf_pkg::csr_req_t  req_i,
    output usbf_pkg::csr_sel_t  sel_o
);
    import usbf_pkg::*;

    logic [ADDR_W-1:0] ep_ofs;
    logic [ADDR_W-1:0] ep_idx;
    logic [ADDR_W-1:0] ep_sub;

    // Position inside the endpoint register windows
    assign ep_ofs = req_i.addr - EP_BASE;
    assign ep_idx = ep_ofs / EP_STRIDE;
    assign ep_sub = ep_ofs % EP_STRIDE;

    always_comb begin
        sel_o.kind  = REG_NONE;
        sel_o.ep    = ep_idx[EP_IDX_W-1:0];
        sel_o.wr    = req_i.wt_en;
        sel_o.rd    = req_i.rd_en;
        sel_o.wdata = req_i.wdata;
        if (req_i.addr >= EP_BASE && ep_idx < ADDR_W'(EP_NUM)) begin
            case (ep_sub)
                EP_CFG_OFS:     sel_o.kind = REG_EP_CFG;
                EP_TX_CTRL_OFS: sel_o.kind = REG_EP_TX_CTRL;
                EP_RX_CTRL_OFS: sel_o.kind = REG_EP_RX_CTRL;
                EP_STS_OFS:     sel_o.kind = REG_EP_STS;
                default:        sel_o.kind = REG_NONE;
            endcase
        end else begin
            case (req_i.addr)
                FUNC_CTRL_ADDR: sel_o.kind = REG_FUNC_CTRL;
                FUNC_STAT_ADDR: sel_o.kind = REG_FUNC_STAT;
                FUNC_ADDR_ADDR: sel_o.kind = REG_FUNC_ADDR;
                EP_INTSTS_ADDR: sel_o.kind = REG_EP_INTSTS;
                default:        sel_o.kind = REG_NONE;
            endcase
        end
    end

    // Bus master never issues a write and a read in the same cycle
    a_no_wr_rd: assert property (@(posedge hclk_i) disable iff (!rst_n_i)
        !(req_i.wt_en && req_i.rd_en));

endmodule

`default_nettype wire

// ==== verilog/usbf_pkg.sv ====
`default_nettype none

package usbf_pkg;

    // ----------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------
    localparam int EP_NUM     = 4;
    localparam int EP_IDX_W   = $clog2(EP_NUM);
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 8;
    localparam int FRAME_W    = 11;
    localparam int LEN_W      = 11;
    localparam int DEV_ADDR_W = 7;

    // ----------------------------------------------------------
    // Address map
    // ----------------------------------------------------------
    localparam logic [ADDR_W-1:0] FUNC_CTRL_ADDR = 8'h00;
    localparam logic [ADDR_W-1:0] FUNC_STAT_ADDR = 8'h04;
    localparam logic [ADDR_W-1:0] FUNC_ADDR_ADDR = 8'h08;
    localparam logic [ADDR_W-1:0] EP_INTSTS_ADDR = 8'h0C;
    localparam logic [ADDR_W-1:0] EP_BASE        = 8'h20;
    localparam logic [ADDR_W-1:0] EP_STRIDE      = 8'h10;
    // Offsets inside one endpoint window
    localparam logic [ADDR_W-1:0] EP_CFG_OFS     = 8'h0;
    localparam logic [ADDR_W-1:0] EP_TX_CTRL_OFS = 8'h4;
    localparam logic [ADDR_W-1:0] EP_RX_CTRL_OFS = 8'h8;
    localparam logic [ADDR_W-1:0] EP_STS_OFS     = 8'hC;

    // ----------------------------------------------------------
    // Field positions
    // ----------------------------------------------------------
    localparam int FC_CHIRP_B     = 0;
    localparam int FC_DM_B        = 1;
    localparam int FC_DP_B        = 2;
    localparam int FC_TERM_B      = 3;
    localparam int FC_XCVR_B      = 4;
    localparam int FC_OPMODE_B    = 6;
    localparam int FC_SOF_EN_B    = 8;
    localparam int FC_RST_EN_B    = 9;
    localparam int FS_SOF_B       = 0;
    localparam int FS_RST_B       = 1;
    localparam int FS_LINE_B      = 2;
    localparam int FS_FRAME_B     = 4;
    localparam int FA_DEV_B       = 0;
    localparam int INTSTS_RX_B    = 0;
    localparam int INTSTS_TX_B    = 16;
    localparam int CFG_INT_RX_B   = 0;
    localparam int CFG_INT_TX_B   = 1;
    localparam int CFG_STALL_B    = 2;
    localparam int CFG_ISO_B      = 3;
    localparam int TX_LEN_B       = 0;
    localparam int TX_FLUSH_B     = 16;
    localparam int TX_START_B     = 17;
    localparam int RX_FLUSH_B     = 0;
    localparam int RX_ACCEPT_B    = 1;
    localparam int STS_COUNT_B    = 0;
    localparam int STS_RX_READY_B = 16;
    localparam int STS_RX_SETUP_B = 17;
    localparam int STS_RX_ERR_B   = 18;
    localparam int STS_TX_BUSY_B  = 19;
    localparam int STS_TX_ERR_B   = 20;

    // ----------------------------------------------------------
    // Types
    // ----------------------------------------------------------
    typedef enum logic [3:0] {
        REG_NONE, REG_FUNC_CTRL, REG_FUNC_STAT, REG_FUNC_ADDR, REG_EP_INTSTS,
        REG_EP_CFG, REG_EP_TX_CTRL, REG_EP_RX_CTRL, REG_EP_STS
    } reg_kind_e;

    typedef struct packed {
        logic              wt_en;
        logic              rd_en;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } csr_req_t;

    typedef struct packed {
        reg_kind_e           kind;
        logic [EP_IDX_W-1:0] ep;
        logic                wr;
        logic                rd;
        logic [DATA_W-1:0]   wdata;
    } csr_sel_t;

    typedef struct packed {
        logic       hs_chirp_en;
        logic       dmpulldown;
        logic       dppulldown;
        logic       termselect;
        logic [1:0] xcvrselect;
        logic [1:0] opmode;
    } phy_ctrl_t;

    typedef struct packed {
        logic [LEN_W-1:0] rx_count;
        logic             rx_ready;
        logic             rx_setup;
        logic             rx_err;
        logic             tx_busy;
        logic             tx_err;
    } ep_status_t;

    typedef struct packed {
        logic tx_start;
        logic tx_flush;
        logic rx_flush;
        logic rx_accept;
    } ep_cmd_t;

    typedef struct packed {
        logic              sof;
        logic              bus_rst;
        logic [EP_NUM-1:0] rx_ready;
        logic [EP_NUM-1:0] tx_complete;
    } intr_event_t;

endpackage

`default_nettype wire
